//--- Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - verilog/csr_pkg.sv
      - verilog/csr_file.sv
      - verilog/irq_arbiter.sv
      - verilog/trap_sequencer.sv
      - verilog/csr_unit.sv
  - target: test
    files:
      - tests/csr_unit_props.sv
      - tests/csr_unit_tb.sv

//--- project.f
verilog/csr_pkg.sv
verilog/csr_file.sv
verilog/irq_arbiter.sv
verilog/trap_sequencer.sv
verilog/csr_unit.sv
tests/csr_unit_props.sv
tests/csr_unit_tb.sv

//--- tests/csr_unit_props.sv
`timescale 1ns/100ps

module csr_unit_props (
    input logic clk,
    input logic arst_n,
    input logic csr_valid,
    input logic csr_stall,
    input logic csr_trap
);

    // Count of failed properties
    int unsigned fail_count;

    initial begin
        fail_count = 0;
    end

    // Trap pulse comes one cycle after the stalled cycle
    trap_after_stall: assert property (
        @(posedge clk) disable iff (!arst_n) csr_trap |-> $past(csr_stall)
    ) else begin
        fail_count++;
        $error("csr_trap high without csr_stall in the previous cycle");
    end

    // Stall only with a request present
    stall_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n) csr_stall |-> csr_valid
    ) else begin
        fail_count++;
        $error("csr_stall high while csr_valid is low");
    end

    // Outputs quiet while reset is held
    quiet_in_reset: assert property (
        @(posedge clk) !arst_n |-> (!csr_trap && !csr_stall)
    ) else begin
        fail_count++;
        $error("csr_trap or csr_stall high during reset");
    end

endmodule

//--- tests/csr_unit_tb.sv
`timescale 1ns/100ps

module csr_unit_tb import csr_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 40;
    localparam int MARGIN_CYCLES   = 50;
    localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + MARGIN_CYCLES) * 20;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            csr_valid;
    csr_req_t        csr_req;
    logic [63:0]     cycle_count = 64'h0000_0002_ffff_fff8;
    logic [63:0]     mtime;
    logic [63:0]     mtimecmp;
    logic            irq_external;
    logic            irq_software;
    logic [XLEN-1:0] csr_rdata;
    logic            csr_stall;
    logic            csr_trap;
    logic [XLEN-1:0] trap_vector;

    // Stimulus bookkeeping
    logic [15:0]          lfsr = 16'd55;
    logic [INST_ID_W-1:0] next_id = '0;
    logic [XLEN-1:0]      last_pc;
    logic [XLEN-1:0]      op;
    string                test_name;

    // Reference model
    priv_mode_e      m_mode;
    logic [XLEN-1:0] m_mscratch;
    logic [XLEN-1:0] m_mepc;
    logic [XLEN-1:0] m_mcause;
    logic [XLEN-1:0] m_mtvec;

    csr_unit csr_unit_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .csr_valid    (csr_valid),
        .csr_req      (csr_req),
        .cycle_count  (cycle_count),
        .mtime        (mtime),
        .mtimecmp     (mtimecmp),
        .irq_external (irq_external),
        .irq_software (irq_software),
        .csr_rdata    (csr_rdata),
        .csr_stall    (csr_stall),
        .csr_trap     (csr_trap),
        .trap_vector  (trap_vector)
    );

    bind csr_unit csr_unit_props props_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .csr_valid (csr_valid),
        .csr_stall (csr_stall),
        .csr_trap  (csr_trap)
    );

    // 20 ns clock
    always begin
        #10 clk = ~clk;
    end

    // Free-running cycle count seen by mcycle
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // One LFSR step per bit
    function automatic logic [XLEN-1:0] rand_bits(input int count);
        logic [XLEN-1:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[XLEN-2:0], lfsr[0]};
        end
        return bits;
    endfunction

    task automatic check_value(input string what, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s / %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // New instruction on the next edge, returns at the following falling edge
    task automatic send(input csr_cmd_e cmd, input logic [11:0] addr,
                        input logic [XLEN-1:0] operand);
        @(posedge clk);
        last_pc = 32'h0000_1000 + {next_id[XLEN-3:0], 2'b00};
        csr_valid       <= 1'b1;
        csr_req.pc      <= last_pc;
        csr_req.cmd     <= cmd;
        csr_req.addr    <= addr;
        csr_req.operand <= operand;
        csr_req.inst_id <= next_id;
        next_id = next_id + 1;
        @(negedge clk);
    endtask

    // Same request held for another cycle
    task automatic hold();
        @(posedge clk);
        @(negedge clk);
    endtask

    // Same id held for another cycle with a new operand, a second commit would show
    task automatic hold_operand(input logic [XLEN-1:0] operand);
        @(posedge clk);
        csr_req.operand <= operand;
        @(negedge clk);
    endtask

    task automatic read_check(input string what, input logic [11:0] addr,
                              input logic [XLEN-1:0] expected);
        send(CMD_NONE, addr, '0);
        check_value(what, expected, csr_rdata);
        check_value({what, " stall"}, 32'd0, csr_stall);
    endtask

    task automatic drive_irq(input logic ext, input logic [63:0] time_now,
                             input logic [63:0] time_cmp);
        @(posedge clk);
        irq_external <= ext;
        mtime        <= time_now;
        mtimecmp     <= time_cmp;
        @(negedge clk);
    endtask

    // Stall now, then one trap pulse carrying the vector
    task automatic expect_redirect(input string what, input logic [XLEN-1:0] vector);
        check_value({what, " stall"}, 32'd1, csr_stall);
        hold();
        check_value({what, " stall released"}, 32'd0, csr_stall);
        check_value({what, " trap pulse"}, 32'd1, csr_trap);
        check_value(what, vector, trap_vector);
    endtask

    // ECALL cause depends on the mode it came from
    task automatic model_ecall();
        m_mepc   = last_pc;
        m_mcause = (m_mode == MODE_USER) ? 32'd8 : 32'd11;
        m_mode   = MODE_MACHINE;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        arst_n       = 1'b0;
        csr_valid    = 1'b0;
        csr_req      = '0;
        mtime        = '0;
        mtimecmp     = '1;
        irq_external = 1'b0;
        irq_software = 1'b0;
        m_mode       = MODE_MACHINE;
        m_mscratch   = '0;
        m_mepc       = '0;
        m_mcause     = '0;
        m_mtvec      = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        test_name = "software access";
        op = rand_bits(32);
        send(CMD_WRITE, ADDR_MSCRATCH, op);
        m_mscratch = op;
        read_check("mscratch after write", ADDR_MSCRATCH, m_mscratch);
        op = rand_bits(32);
        send(CMD_SET, ADDR_MSCRATCH, op);
        m_mscratch = m_mscratch | op;
        read_check("mscratch after set", ADDR_MSCRATCH, m_mscratch);
        op = rand_bits(32);
        send(CMD_CLEAR, ADDR_MSCRATCH, op);
        m_mscratch = m_mscratch & ~op;
        read_check("mscratch after clear", ADDR_MSCRATCH, m_mscratch);
        // Set held for two cycles commits once
        op = rand_bits(32);
        send(CMD_SET, ADDR_MSCRATCH, op);
        hold_operand(~op);
        m_mscratch = m_mscratch | op;
        read_check("mscratch after held set", ADDR_MSCRATCH, m_mscratch);

        test_name = "read-only registers";
        read_check("misa", ADDR_MISA, 32'h4010_0100);
        send(CMD_NONE, ADDR_MCYCLE, '0);
        check_value("mcycle", cycle_count[31:0], csr_rdata);
        check_value("mcycle stall", 32'd0, csr_stall);
        send(CMD_NONE, ADDR_MCYCLEH, '0);
        check_value("mcycleh", cycle_count[63:32], csr_rdata);
        check_value("mcycleh stall", 32'd0, csr_stall);
        read_check("unknown address", 12'h7c0, 32'd0);

        test_name = "machine ecall";
        m_mtvec = rand_bits(24) << 8;
        send(CMD_WRITE, ADDR_MTVEC, m_mtvec);
        send(CMD_ECALL, 12'h000, '0);
        expect_redirect("ecall vector", m_mtvec);
        model_ecall();
        hold();
        check_value("no second pulse", 32'd0, csr_trap);
        read_check("mcause", ADDR_MCAUSE, m_mcause);
        read_check("mepc", ADDR_MEPC, m_mepc);

        test_name = "mret to user";
        // MPP = user
        send(CMD_WRITE, ADDR_MSTATUS, 32'h0);
        op = rand_bits(32);
        send(CMD_WRITE, ADDR_MEPC, op);
        m_mepc = {op[XLEN-1:2], 2'b00};
        send(CMD_MRET, 12'h000, '0);
        expect_redirect("mret vector", m_mepc);
        m_mode = MODE_USER;
        op = rand_bits(32);
        send(CMD_WRITE, ADDR_MSCRATCH, op);
        check_value("user write read", 32'd0, csr_rdata);
        read_check("user mscratch", ADDR_MSCRATCH, 32'd0);
        send(CMD_ECALL, 12'h000, '0);
        expect_redirect("user ecall vector", m_mtvec);
        model_ecall();
        read_check("mcause", ADDR_MCAUSE, m_mcause);
        read_check("mscratch kept", ADDR_MSCRATCH, m_mscratch);

        test_name = "timer interrupt";
        m_mtvec = (rand_bits(24) << 8) | 32'h1;
        send(CMD_WRITE, ADDR_MTVEC, m_mtvec);
        // MTIE
        send(CMD_WRITE, ADDR_MIE, 32'h80);
        drive_irq(1'b0, 64'd100, 64'd50);
        // MIE still clear in this cycle
        send(CMD_WRITE, ADDR_MSTATUS, 32'h8);
        check_value("stall before enable", 32'd0, csr_stall);
        // Interrupted write must not land
        op = rand_bits(32);
        send(CMD_WRITE, ADDR_MSCRATCH, op);
        expect_redirect("timer vector", (m_mtvec & ~32'h3) + 32'd28);
        m_mepc   = last_pc;
        m_mcause = 32'h8000_0007;
        read_check("timer mcause", ADDR_MCAUSE, m_mcause);
        read_check("timer mepc", ADDR_MEPC, m_mepc);
        read_check("mscratch untouched", ADDR_MSCRATCH, m_mscratch);
        // MEI outranks MTI
        send(CMD_WRITE, ADDR_MIE, 32'h880);
        drive_irq(1'b1, 64'd100, 64'd50);
        send(CMD_WRITE, ADDR_MSTATUS, 32'h8);
        op = rand_bits(32);
        send(CMD_WRITE, ADDR_MSCRATCH, op);
        expect_redirect("external vector", (m_mtvec & ~32'h3) + 32'd44);
        m_mcause = 32'h8000_000b;
        read_check("external mcause", ADDR_MCAUSE, m_mcause);
        drive_irq(1'b0, 64'd0, '1);

        test_name = "masked interrupt";
        // MIE left clear by the last trap
        drive_irq(1'b0, 64'd100, 64'd50);
        read_check("mip pending", ADDR_MIP, 32'h80);
        // Next instruction sees the last cycle's trap and its own stall
        send(CMD_NONE, ADDR_MIP, '0);
        check_value("trap while masked", 32'd0, csr_trap);
        check_value("stall while masked", 32'd0, csr_stall);

        @(posedge clk);
        csr_valid <= 1'b0;
        @(negedge clk);
        if (csr_unit_i.props_i.fail_count != 0) begin
            $display("Bound property checks failed %0d times", csr_unit_i.props_i.fail_count);
            $display("** FAIL **");
            $fatal(1);
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- verilog/csr_file.sv
`timescale 1ns/100ps

module csr_file import csr_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  csr_req_t     csr_req,
    input  logic         sw_commit,
    input  trap_action_t trap_action,
    input  irq_pending_t irq_pending,
    input  logic [63:0]  cycle_count,
    output logic [XLEN-1:0] csr_rdata,
    output csr_state_t   csr_state
);

    // Architectural state
    priv_mode_e      mode;
    logic            mstatus_mie;
    logic            mstatus_mpie;
    priv_mode_e      mstatus_mpp;
    logic [2:0]      mie_en;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    // Read path and write data
    logic [XLEN-1:0] rd_data;
    logic [XLEN-1:0] wdata;
    logic            can_access;
    logic            can_write;

    // Bits 9:8 give the lowest mode allowed, 11:10 = 3 marks read-only
    assign can_access = csr_req.addr[9:8] <= mode;
    assign can_write  = can_access && (csr_req.addr[11:10] != 2'b11);

    // Read multiplexer, unknown addresses read zero
    always_comb begin
        rd_data = '0;
        case (csr_req.addr)
            ADDR_MSTATUS: begin
                rd_data[MSTATUS_MIE_BIT]         = mstatus_mie;
                rd_data[MSTATUS_MPIE_BIT]        = mstatus_mpie;
                rd_data[MSTATUS_MPP_LSB +: 2]    = mstatus_mpp;
            end
            ADDR_MISA:     rd_data = MISA_VALUE;
            ADDR_MIE: begin
                rd_data[IRQ_MEI_BIT] = mie_en[2];
                rd_data[IRQ_MSI_BIT] = mie_en[1];
                rd_data[IRQ_MTI_BIT] = mie_en[0];
            end
            ADDR_MTVEC:    rd_data = mtvec;
            ADDR_MSCRATCH: rd_data = mscratch;
            ADDR_MEPC:     rd_data = mepc;
            ADDR_MCAUSE:   rd_data = mcause;
            ADDR_MIP: begin
                rd_data[IRQ_MEI_BIT] = irq_pending.meip;
                rd_data[IRQ_MSI_BIT] = irq_pending.msip;
                rd_data[IRQ_MTI_BIT] = irq_pending.mtip;
            end
            // Both counter views map onto the same 64-bit count
            ADDR_MCYCLE,
            ADDR_CYCLE:    rd_data = cycle_count[31:0];
            ADDR_MCYCLEH,
            ADDR_CYCLEH:   rd_data = cycle_count[63:32];
            // Single hart
            ADDR_MHARTID:  rd_data = '0;
            default:       rd_data = '0;
        endcase
    end

    // Denied access reads as zero, no trap
    assign csr_rdata = can_access ? rd_data : '0;

    // Read-modify-write value for the three software commands
    always_comb begin
        case (csr_req.cmd)
            CMD_WRITE: wdata = csr_req.operand;
            CMD_SET:   wdata = rd_data | csr_req.operand;
            CMD_CLEAR: wdata = rd_data & ~csr_req.operand;
            default:   wdata = rd_data;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode         <= MODE_MACHINE;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= MODE_MACHINE;
            mie_en       <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else if (trap_action.take_trap) begin
            // Interrupt or ECALL, always handled in machine mode
            mcause       <= trap_action.cause;
            mepc         <= csr_req.pc;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= mode;
            mode         <= MODE_MACHINE;
        end else if (trap_action.take_mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mode         <= mstatus_mpp;
            // Lowest supported mode
            mstatus_mpp  <= MODE_USER;
        end else if (sw_commit && can_write) begin
            case (csr_req.addr)
                ADDR_MSTATUS: begin
                    mstatus_mie  <= wdata[MSTATUS_MIE_BIT];
                    mstatus_mpie <= wdata[MSTATUS_MPIE_BIT];
                    // WARL, only user and machine are legal
                    mstatus_mpp  <= (wdata[MSTATUS_MPP_LSB +: 2] == 2'b11) ?
                                    MODE_MACHINE : MODE_USER;
                end
                ADDR_MIE: begin
                    mie_en <= {wdata[IRQ_MEI_BIT], wdata[IRQ_MSI_BIT], wdata[IRQ_MTI_BIT]};
                end
                ADDR_MTVEC:    mtvec    <= wdata;
                ADDR_MSCRATCH: mscratch <= wdata;
                // Instructions are word aligned
                ADDR_MEPC:     mepc     <= {wdata[XLEN-1:2], 2'b00};
                ADDR_MCAUSE:   mcause   <= wdata;
                // mip bits follow the sources, misa is fixed
                default: begin
                end
            endcase
        end
    end

    // State seen by the arbiter and the sequencer
    assign csr_state.mode        = mode;
    assign csr_state.mstatus_mie = mstatus_mie;
    assign csr_state.mstatus_mpp = mstatus_mpp;
    assign csr_state.mie_en      = mie_en;
    assign csr_state.mtvec       = mtvec;
    assign csr_state.mepc        = mepc;

endmodule

//--- verilog/csr_pkg.sv
package csr_pkg;

    // Datapath and instruction id widths
    localparam int XLEN      = 32;
    localparam int INST_ID_W = 64;

    // Saved id after reset, so that a first id of 0 counts as new
    localparam logic [INST_ID_W-1:0] INST_ID_RESET = 64'hffff_0000_0000_0000;

    // Machine trap setup
    localparam logic [11:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [11:0] ADDR_MISA     = 12'h301;
    localparam logic [11:0] ADDR_MIE      = 12'h304;
    localparam logic [11:0] ADDR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam logic [11:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [11:0] ADDR_MEPC     = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [11:0] ADDR_MIP      = 12'h344;

    // Counters, machine and user views
    localparam logic [11:0] ADDR_MCYCLE   = 12'hb00;
    localparam logic [11:0] ADDR_MCYCLEH  = 12'hb80;
    localparam logic [11:0] ADDR_CYCLE    = 12'hc00;
    localparam logic [11:0] ADDR_CYCLEH   = 12'hc80;

    // Machine information
    localparam logic [11:0] ADDR_MHARTID  = 12'hf14;

    // MXL = 1 (32 bit), extensions I and U
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4010_0100;

    // Exception causes
    localparam logic [XLEN-1:0] CAUSE_ECALL_U = 32'd8;
    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

    // Interrupt causes, bit 31 marks an interrupt
    localparam logic [XLEN-1:0] CAUSE_IRQ_MSI = 32'h8000_0003;
    localparam logic [XLEN-1:0] CAUSE_IRQ_MTI = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_IRQ_MEI = 32'h8000_000b;

    // Field positions in mstatus
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // Shared bit positions of mie and mip
    localparam int IRQ_MSI_BIT = 3;
    localparam int IRQ_MTI_BIT = 7;
    localparam int IRQ_MEI_BIT = 11;

    // mtvec mode field value for vectored interrupts
    localparam logic [1:0] MTVEC_VECTORED = 2'b01;

    typedef enum logic [1:0] {
        MODE_USER    = 2'b00,
        MODE_MACHINE = 2'b11
    } priv_mode_e;

    // Values above 3 are system commands
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_SET   = 3'd2,
        CMD_CLEAR = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        csr_cmd_e             cmd;
        logic [11:0]          addr;
        logic [XLEN-1:0]      operand;
        logic [INST_ID_W-1:0] inst_id;
    } csr_req_t;

    // mie_en order is MEI, MSI, MTI from the top
    typedef struct packed {
        priv_mode_e      mode;
        logic            mstatus_mie;
        priv_mode_e      mstatus_mpp;
        logic [2:0]      mie_en;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mepc;
    } csr_state_t;

    typedef struct packed {
        logic meip;
        logic msip;
        logic mtip;
    } irq_pending_t;

    typedef struct packed {
        logic            take_trap;
        logic            take_mret;
        logic [XLEN-1:0] cause;
    } trap_action_t;

endpackage

//--- verilog/csr_unit.sv
`timescale 1ns/100ps

module csr_unit import csr_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            csr_valid,
    input  csr_req_t        csr_req,
    input  logic [63:0]     cycle_count,
    input  logic [63:0]     mtime,
    input  logic [63:0]     mtimecmp,
    input  logic            irq_external,
    input  logic            irq_software,
    output logic [XLEN-1:0] csr_rdata,
    output logic            csr_stall,
    output logic            csr_trap,
    output logic [XLEN-1:0] trap_vector
);

    // Internal links between the three blocks
    csr_state_t      csr_state;
    irq_pending_t    irq_pending;
    logic            take_irq;
    logic [XLEN-1:0] irq_cause;
    logic            sw_commit;
    trap_action_t    trap_action;

    // Register storage and read path
    csr_file csr_file_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .csr_req     (csr_req),
        .sw_commit   (sw_commit),
        .trap_action (trap_action),
        .irq_pending (irq_pending),
        .cycle_count (cycle_count),
        .csr_rdata   (csr_rdata),
        .csr_state   (csr_state)
    );

    // Interrupt sampling and priority
    irq_arbiter irq_arbiter_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .irq_external (irq_external),
        .irq_software (irq_software),
        .mtime        (mtime),
        .mtimecmp     (mtimecmp),
        .csr_state    (csr_state),
        .irq_pending  (irq_pending),
        .take_irq     (take_irq),
        .irq_cause    (irq_cause)
    );

    // Stall, commit and redirect control
    trap_sequencer trap_sequencer_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .csr_valid   (csr_valid),
        .csr_req     (csr_req),
        .csr_state   (csr_state),
        .take_irq    (take_irq),
        .irq_cause   (irq_cause),
        .csr_stall   (csr_stall),
        .sw_commit   (sw_commit),
        .trap_action (trap_action),
        .csr_trap    (csr_trap),
        .trap_vector (trap_vector)
    );

endmodule

//--- verilog/irq_arbiter.sv
`timescale 1ns/100ps

module irq_arbiter import csr_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            irq_external,
    input  logic            irq_software,
    input  logic [63:0]     mtime,
    input  logic [63:0]     mtimecmp,
    input  csr_state_t      csr_state,
    output irq_pending_t    irq_pending,
    output logic            take_irq,
    output logic [XLEN-1:0] irq_cause
);

    irq_pending_t pending_q;
    logic [2:0]   qualified;
    logic         global_en;

    // Sources sampled every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= '0;
        end else begin
            pending_q.meip <= irq_external;
            pending_q.msip <= irq_software;
            // Timer fires once mtime reaches the compare value
            pending_q.mtip <= (mtime >= mtimecmp);
        end
    end

    assign irq_pending = pending_q;

    // User mode is always interruptible by machine interrupts
    assign global_en = (csr_state.mode == MODE_USER) || csr_state.mstatus_mie;

    // Pending and enabled, in MEI, MSI, MTI order
    assign qualified = {pending_q.meip, pending_q.msip, pending_q.mtip} & csr_state.mie_en;

    assign take_irq = global_en && (|qualified);

    // Fixed priority MEI > MSI > MTI
    always_comb begin
        if (qualified[2]) begin
            irq_cause = CAUSE_IRQ_MEI;
        end else if (qualified[1]) begin
            irq_cause = CAUSE_IRQ_MSI;
        end else if (qualified[0]) begin
            irq_cause = CAUSE_IRQ_MTI;
        end else begin
            irq_cause = '0;
        end
    end

endmodule

//--- verilog/trap_sequencer.sv
`timescale 1ns/100ps

module trap_sequencer import csr_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            csr_valid,
    input  csr_req_t        csr_req,
    input  csr_state_t      csr_state,
    input  logic            take_irq,
    input  logic [XLEN-1:0] irq_cause,
    output logic            csr_stall,
    output logic            sw_commit,
    output trap_action_t    trap_action,
    output logic            csr_trap,
    output logic [XLEN-1:0] trap_vector
);

    logic [INST_ID_W-1:0] saved_id;
    logic                 new_cycle;
    logic                 is_ecall;
    logic                 is_mret;
    logic                 is_sw_op;
    logic [XLEN-1:0]      ecall_cause;
    logic [XLEN-1:0]      mtvec_base;
    logic [XLEN-1:0]      irq_vector;
    logic [XLEN-1:0]      next_vector;
    logic                 redirect;

    // Id of the last request seen, repeats of it are ignored
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            saved_id <= INST_ID_RESET;
        end else if (csr_valid) begin
            saved_id <= csr_req.inst_id;
        end
    end

    // First cycle of an instruction
    assign new_cycle = csr_valid && (csr_req.inst_id != saved_id);

    assign is_ecall = csr_req.cmd == CMD_ECALL;
    assign is_mret  = csr_req.cmd == CMD_MRET;
    assign is_sw_op = (csr_req.cmd == CMD_WRITE) || (csr_req.cmd == CMD_SET) ||
                      (csr_req.cmd == CMD_CLEAR);

    // Hold the pipeline for one cycle on any redirect
    assign csr_stall = new_cycle && (is_ecall || is_mret || take_irq);

    // Interrupt replaces the instruction, so it never commits
    assign sw_commit = new_cycle && !take_irq && is_sw_op;

    // Cause depends on the mode the call came from
    assign ecall_cause = (csr_state.mode == MODE_USER) ? CAUSE_ECALL_U : CAUSE_ECALL_M;

    always_comb begin
        trap_action.take_trap = new_cycle && (take_irq || is_ecall);
        trap_action.take_mret = new_cycle && !take_irq && is_mret;
        trap_action.cause     = take_irq ? irq_cause : ecall_cause;
    end

    assign redirect = trap_action.take_trap || trap_action.take_mret;

    // Base address with the mode bits masked off
    assign mtvec_base = {csr_state.mtvec[XLEN-1:2], 2'b00};

    // Vectored mode adds 4 x cause code, bit 31 drops out of the shift
    assign irq_vector = (csr_state.mtvec[1:0] == MTVEC_VECTORED) ?
                        mtvec_base + {irq_cause[XLEN-3:0], 2'b00} : mtvec_base;

    always_comb begin
        if (take_irq) begin
            next_vector = irq_vector;
        end else if (is_mret) begin
            next_vector = csr_state.mepc;
        end else begin
            // ECALL always lands on the base
            next_vector = mtvec_base;
        end
    end

    // One-cycle trap pulse after the stalled cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_trap <= 1'b0;
        end else begin
            csr_trap <= redirect;
        end
    end

    // Vector lines up with the pulse
    always_ff @(posedge clk) begin
        if (redirect) begin
            trap_vector <= next_vector;
        end
    end

endmodule
